// ==== verilog/mipsAluPkg.sv ====
// MIPS execute unit shared types
`default_nettype none

package mipsAluPkg;

    // alu operation codes, same order as the base alu
    typedef enum logic [3:0] {
        ALU_SLL  = 4'd0,        // sll, sllv
        ALU_SRL  = 4'd1,        // srl, srlv
        ALU_SRA  = 4'd2,        // sra, srav
        ALU_ADD  = 4'd3,        // add, addu, addi, addiu
        ALU_SUB  = 4'd4,        // sub, subu
        ALU_AND  = 4'd5,        // and, andi
        ALU_OR   = 4'd6,        // or, ori
        ALU_XOR  = 4'd7,        // xor, xori
        ALU_NOR  = 4'd8,        // nor
        ALU_SLT  = 4'd9,        // slt, slti
        ALU_SLTU = 4'd10,       // sltu, sltiu
        ALU_LUI  = 4'd11,       // lui
        ALU_MUL  = 4'd12        // special2 mul
    } aluOpE;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_ADDI     = 6'h08;   // no trap here
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;

    // funct codes for special
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;
    localparam logic [5:0] FN_MUL  = 6'h02;       // funct under special2

    // host address map, regfile words sit at 0x00..0x7c
    localparam logic [7:0] ADDR_INSTR  = 8'h80;
    localparam logic [7:0] ADDR_STATUS = 8'h84;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeS;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeS;

    // one instruction word, viewed per opcode
    typedef union packed {
        rTypeS r;
        iTypeS i;
    } mipsInstrU;

    typedef struct packed {
        logic       valid;
        aluOpE      op;
        logic [31:0] x;         // shamt, rs or don't care for lui
        logic [31:0] y;         // rt or extended imm
        logic [4:0]  dest;
    } aluReqS;

    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] data;
    } wbS;

endpackage

`default_nettype wire

// ==== verilog/apbSlave.sv ====
// APB host interface
`timescale 1ns/1ps
`default_nettype none

module apbSlave (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [7:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  execStart,      // one cycle, first access cycle
    output mipsAluPkg::mipsInstrU execInstr,
    input  logic                  illegal,
    input  mipsAluPkg::wbS        wb,
    output logic                  hostWe,
    output logic [4:0]            hostAddr,
    output logic [31:0]           hostWdata,
    input  logic [31:0]           hostRdata
);
    import mipsAluPkg::*;

    logic        setupPhase;
    logic        accessPhase;
    logic        instrSetup;      // setup of a write to the command reg
    logic        statusWrite;
    logic        readyReg;
    logic        illegalFlag;     // sticky
    logic [15:0] execCount;       // legal instructions retired

    assign setupPhase  = psel & ~penable;
    assign accessPhase = psel & penable;
    assign instrSetup  = setupPhase & pwrite & (paddr == ADDR_INSTR);
    assign statusWrite = accessPhase & pwrite & (paddr == ADDR_STATUS);

    // illegal word finishes on the decoder pulse itself
    assign pready = readyReg | illegal;

    // regfile window is the lower half of the map
    assign hostWe    = accessPhase & pwrite & ~paddr[7];
    assign hostAddr  = paddr[6:2];                  // word address
    assign hostWdata = pwdata;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readyReg    <= 1'b0;
            execStart   <= 1'b0;
            execInstr   <= '0;
            illegalFlag <= 1'b0;
            execCount   <= 16'd0;
        end else begin
            execStart <= instrSetup;                // lands in first access cycle
            // zero-wait for plain accesses, else wait for write-back
            readyReg  <= (setupPhase & ~instrSetup) | wb.valid;
            if (instrSetup) begin
                execInstr <= pwdata;                // also read back at 0x80
            end
            if (illegal) begin
                illegalFlag <= 1'b1;
            end else if (statusWrite) begin
                illegalFlag <= 1'b0;                // any write clears
            end
            if (wb.valid) begin
                execCount <= execCount + 16'd1;
            end
        end
    end

    // read mux
    always_comb begin
        if (!paddr[7]) begin
            prdata = hostRdata;                     // regfile, r0 reads 0
        end else if (paddr == ADDR_INSTR) begin
            prdata = execInstr;
        end else if (paddr == ADDR_STATUS) begin
            prdata = {execCount, 15'd0, illegalFlag};
        end else begin
            prdata = 32'd0;                         // unmapped
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
// MIPS instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  execStart,
    input  mipsAluPkg::mipsInstrU execInstr,
    output logic [4:0]            rsAddr,
    output logic [4:0]            rtAddr,
    input  logic [31:0]           rsData,
    input  logic [31:0]           rtData,
    output mipsAluPkg::aluReqS    aluReq,
    output logic                  illegal         // one cycle pulse
);
    import mipsAluPkg::*;

    aluOpE       nextOp;
    logic [31:0] nextX;
    logic [31:0] nextY;
    logic [4:0]  nextDest;
    logic        legal;
    logic [31:0] immSext;
    logic [31:0] immZext;

    // rs and rt sit at the same bits in both views
    assign rsAddr  = execInstr.r.rs;
    assign rtAddr  = execInstr.r.rt;
    assign immSext = {{16{execInstr.i.imm[15]}}, execInstr.i.imm};
    assign immZext = {16'd0, execInstr.i.imm};

    always_comb begin
        nextOp   = ALU_ADD;
        nextX    = rsData;                          // r-type default operands
        nextY    = rtData;
        nextDest = execInstr.r.rd;
        legal    = 1'b1;
        case (execInstr.r.opcode)
            OP_SPECIAL: begin
                case (execInstr.r.funct)
                    FN_SLL:  begin nextOp = ALU_SLL; nextX = {27'd0, execInstr.r.shamt}; end
                    FN_SRL:  begin nextOp = ALU_SRL; nextX = {27'd0, execInstr.r.shamt}; end
                    FN_SRA:  begin nextOp = ALU_SRA; nextX = {27'd0, execInstr.r.shamt}; end
                    FN_SLLV: nextOp = ALU_SLL;      // amount from rs[4:0]
                    FN_SRLV: nextOp = ALU_SRL;
                    FN_SRAV: nextOp = ALU_SRA;
                    FN_ADD, FN_ADDU: nextOp = ALU_ADD;  // no overflow trap
                    FN_SUB, FN_SUBU: nextOp = ALU_SUB;
                    FN_AND:  nextOp = ALU_AND;
                    FN_OR:   nextOp = ALU_OR;
                    FN_XOR:  nextOp = ALU_XOR;
                    FN_NOR:  nextOp = ALU_NOR;
                    FN_SLT:  nextOp = ALU_SLT;
                    FN_SLTU: nextOp = ALU_SLTU;
                    default: legal  = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                nextOp = ALU_MUL;
                legal  = (execInstr.r.funct == FN_MUL);
            end
            // i-type writes rt
            OP_ADDI, OP_ADDIU: begin nextOp = ALU_ADD;  nextY = immSext; nextDest = rtAddr; end
            OP_SLTI:           begin nextOp = ALU_SLT;  nextY = immSext; nextDest = rtAddr; end
            OP_SLTIU:          begin nextOp = ALU_SLTU; nextY = immSext; nextDest = rtAddr; end
            OP_ANDI:           begin nextOp = ALU_AND;  nextY = immZext; nextDest = rtAddr; end
            OP_ORI:            begin nextOp = ALU_OR;   nextY = immZext; nextDest = rtAddr; end
            OP_XORI:           begin nextOp = ALU_XOR;  nextY = immZext; nextDest = rtAddr; end
            OP_LUI:            begin nextOp = ALU_LUI;  nextY = immZext; nextDest = rtAddr; end
            default: legal = 1'b0;                  // branches, loads, stores etc
        endcase
    end

    always_ff @(posedge clk) begin
        if (execStart) begin
            aluReq.op   <= nextOp;                  // payload, no reset
            aluReq.x    <= nextX;
            aluReq.y    <= nextY;
            aluReq.dest <= nextDest;
        end
        if (!rstN) begin
            aluReq.valid <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            aluReq.valid <= execStart & legal;
            illegal      <= execStart & ~legal;     // nothing issued
        end
    end

endmodule

`default_nettype wire

// ==== verilog/arithLogicUnit.sv ====
// Registered ALU stage
`timescale 1ns/1ps
`default_nettype none

module arithLogicUnit (
    input  logic               clk,
    input  logic               rstN,
    input  mipsAluPkg::aluReqS aluReq,
    output mipsAluPkg::wbS     wb
);
    import mipsAluPkg::*;

    logic [31:0] result;
    logic [31:0] x;
    logic [31:0] y;

    assign x = aluReq.x;
    assign y = aluReq.y;

    always_comb begin
        case (aluReq.op)
            ALU_SLL:  result = y << x[4:0];                 // only low 5 bits count
            ALU_SRL:  result = y >> x[4:0];
            ALU_SRA:  result = $signed(y) >>> x[4:0];       // sign fill
            ALU_ADD:  result = x + y;
            ALU_SUB:  result = x - y;
            ALU_AND:  result = x & y;
            ALU_OR:   result = x | y;
            ALU_XOR:  result = x ^ y;
            ALU_NOR:  result = ~(x | y);
            ALU_SLT:  result = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            ALU_SLTU: result = (x < y) ? 32'd1 : 32'd0;
            ALU_LUI:  result = {y[15:0], 16'h0000};
            ALU_MUL:  result = x * y;                       // low word only
            default:  result = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        wb.dest <= aluReq.dest;                     // follows valid
        wb.data <= result;
        if (!rstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= aluReq.valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// 32x32 register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic [4:0]     rsAddr,
    input  logic [4:0]     rtAddr,
    output logic [31:0]    rsData,
    output logic [31:0]    rtData,
    input  logic           hostWe,
    input  logic [4:0]     hostAddr,
    input  logic [31:0]    hostWdata,
    output logic [31:0]    hostRdata,
    input  mipsAluPkg::wbS wb
);
    logic [31:0] regs [32];

    // r0 hardwired to zero on every read port
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        readPort = (addr == 5'd0) ? 32'd0 : regs[addr];
    endfunction

    assign rsData    = readPort(rsAddr);
    assign rtData    = readPort(rtAddr);
    assign hostRdata = readPort(hostAddr);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (hostWe) begin
            if (hostAddr != 5'd0) begin
                regs[hostAddr] <= hostWdata;        // host wins on a tie
            end
        end else if (wb.valid) begin
            if (wb.dest != 5'd0) begin
                regs[wb.dest] <= wb.data;           // write-back
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mipsAluTop.sv ====
// MIPS execute unit top level
`timescale 1ns/1ps
`default_nettype none

module mipsAluTop (
    input  logic        clk,
    input  logic        rstN,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);
    import mipsAluPkg::*;

    logic        execStart;
    mipsInstrU   execInstr;
    logic        illegal;
    aluReqS      aluReq;          // decoder to alu
    wbS          wb;              // alu to regfile and apb
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic        hostWe;
    logic [4:0]  hostAddr;
    logic [31:0] hostWdata;
    logic [31:0] hostRdata;

    apbSlave apbSlave_i (
        .clk(clk), .rstN(rstN),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .execStart(execStart), .execInstr(execInstr),
        .illegal(illegal), .wb(wb),
        .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata), .hostRdata(hostRdata)
    );

    instrDecoder instrDecoder_i (
        .clk(clk), .rstN(rstN),
        .execStart(execStart), .execInstr(execInstr),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .aluReq(aluReq), .illegal(illegal)
    );

    arithLogicUnit arithLogicUnit_i (
        .clk(clk), .rstN(rstN),
        .aluReq(aluReq), .wb(wb)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata), .hostRdata(hostRdata),
        .wb(wb)
    );

endmodule

`default_nettype wire

// ==== testbench/tbMipsAlu.sv ====
// MIPS execute unit testbench
`timescale 1ns/1ps
`default_nettype none

module tbMipsAlu;
    import mipsAluPkg::*;

    logic        clk;
    logic        rstN;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] model [32];              // expected register contents
    int          seed = 32'h00ff_8ef4;
    int          errorCount = 0;
    int          checkCount = 0;
    int          legalCount = 0;          // legal instructions issued

    mipsAluTop dut_i (
        .clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;           // 40 ns period
    end

    task automatic finishRun();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // one apb transfer, pready sampled mid-cycle
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           input int expWaits, output logic [31:0] rdata);
        int waitCycles;
        @(posedge clk);
        #2;
        psel    = 1'b1;                   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;                   // access phase
        waitCycles = 0;
        @(negedge clk);
        while (!pready && waitCycles < 50) begin
            waitCycles++;
            @(negedge clk);
        end
        if (!pready) begin
            errorCount++;
            $display("ERROR: pready never came for address %h after 50 cycles", addr);
            finishRun();
        end else begin
            checkWaits($sformatf("apb %s %h", wr ? "wr" : "rd", addr), expWaits, waitCycles);
            rdata = prdata;
            @(posedge clk);               // transfer ends here
            #2;
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata,
                            input int expWaits);
        logic [31:0] unused;
        apbXfer(1'b1, addr, wdata, expWaits, unused);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata);
        apbXfer(1'b0, addr, 32'd0, 0, rdata);   // reads never wait
    endtask

    function automatic logic [7:0] regAddr(input logic [4:0] idx);
        regAddr = {1'b0, idx, 2'b00};     // word aligned window
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkStatus(input string name, input logic expIllegal,
                               input logic [15:0] expCount, input logic [31:0] act);
        checkCount++;
        if (act[0] !== expIllegal || act[31:16] !== expCount) begin
            errorCount++;
            $display("FAIL %s: expected illegal %b count %0d, actual illegal %b count %0d",
                     name, expIllegal, expCount, act[0], act[31:16]);
        end
    endtask

    task automatic checkOp(input string name, input aluOpE op, input logic [31:0] exp,
                           input logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s (%s): expected %h, actual %h", name, op.name(), exp, act);
        end
    endtask

    task automatic checkWaits(input string name, input int exp, input int act);
        checkCount++;
        if (act != exp) begin
            errorCount++;
            $display("FAIL %s: expected %0d wait states, actual %0d", name, exp, act);
        end
    endtask

    // expected result from MIPS semantics
    function automatic logic [31:0] refAlu(input aluOpE op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [4:0] amt);
        logic [63:0] wide;
        logic [31:0] res;
        wide = 64'd0;
        case (op)
            ALU_SLL:  res = b << amt;
            ALU_SRL:  res = b >> amt;
            ALU_SRA: begin
                wide = {{32{b[31]}}, b} >> amt;             // sign copies shift in
                res  = wide[31:0];
            end
            ALU_ADD:  res = a + b;                          // wraps, no trap
            ALU_SUB:  res = a + ~b + 32'd1;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_NOR:  res = ~a & ~b;
            ALU_SLT:  res = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: res = {31'd0, a < b};
            ALU_LUI:  res = {b[15:0], 16'h0000};
            ALU_MUL: begin
                wide = {32'd0, a} * {32'd0, b};             // low word kept
                res  = wide[31:0];
            end
            default:  res = 32'd0;
        endcase
        refAlu = res;
    endfunction

    task automatic loadReg(input logic [4:0] idx, input logic [31:0] value);
        apbWrite(regAddr(idx), value, 0);
        if (idx != 5'd0) begin
            model[idx] = value;
        end
    endtask

    task automatic runR(input string name, input logic [5:0] opc, input logic [5:0] funct,
                        input aluOpE op, input logic [4:0] rs, input logic [4:0] rt,
                        input logic [4:0] rd, input logic [4:0] shamt);
        rTypeS       instr;
        logic [31:0] expected;
        logic [31:0] rdata;
        logic [4:0]  amount;
        instr  = {opc, rs, rt, rd, shamt, funct};
        amount = model[rs][4:0];                            // variable shifts use rs
        if (opc == OP_SPECIAL && funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
            amount = shamt;
        end
        expected = refAlu(op, model[rs], model[rt], amount);
        apbWrite(ADDR_INSTR, instr, 3);                     // decode, alu, write-back
        legalCount++;
        if (rd != 5'd0) begin
            model[rd] = expected;
        end
        apbRead(regAddr(rd), rdata);
        checkOp(name, op, model[rd], rdata);                // r0 stays zero
    endtask

    task automatic runI(input string name, input logic [5:0] opc, input aluOpE op,
                        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        iTypeS       instr;
        logic [31:0] ext;
        logic [31:0] rdata;
        instr = {opc, rs, rt, imm};
        ext   = {{16{imm[15]}}, imm};
        if (opc inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
            ext = {16'd0, imm};                             // logical forms zero extend
        end
        apbWrite(ADDR_INSTR, instr, 3);
        legalCount++;
        if (rt != 5'd0) begin
            model[rt] = refAlu(op, model[rs], ext, 5'd0);
        end
        apbRead(regAddr(rt), rdata);
        checkOp(name, op, model[rt], rdata);
    endtask

    task automatic compareAllRegs(input string name);
        logic [31:0] rdata;
        for (int i = 0; i < 32; i++) begin
            apbRead(regAddr(5'(i)), rdata);
            checkWord(name, model[i], rdata);
        end
    endtask

    task automatic testRegFile();
        compareAllRegs("reset value");
        for (int i = 0; i < 32; i++) begin
            loadReg(5'(i), 32'h0101_0101 * i + 32'h5a00_0000);
        end
        compareAllRegs("regfile readback");                 // r0 must read 0
    endtask

    task automatic testRType();
        loadReg(5'd1, $random(seed));
        loadReg(5'd2, $random(seed));
        loadReg(5'd3, 32'h8000_0000);                       // most negative
        loadReg(5'd4, 32'h7fff_ffff);
        loadReg(5'd5, 32'hffff_ffff);
        loadReg(5'd6, 32'h0000_0001);
        loadReg(5'd7, $random(seed));
        runR("addu", OP_SPECIAL, FN_ADDU, ALU_ADD, 5'd1, 5'd2, 5'd8, 5'd0);
        runR("add wraps", OP_SPECIAL, FN_ADD, ALU_ADD, 5'd4, 5'd6, 5'd9, 5'd0);
        runR("subu", OP_SPECIAL, FN_SUBU, ALU_SUB, 5'd1, 5'd2, 5'd10, 5'd0);
        runR("sub", OP_SPECIAL, FN_SUB, ALU_SUB, 5'd3, 5'd6, 5'd11, 5'd0);
        runR("and", OP_SPECIAL, FN_AND, ALU_AND, 5'd1, 5'd7, 5'd12, 5'd0);
        runR("or", OP_SPECIAL, FN_OR, ALU_OR, 5'd1, 5'd7, 5'd13, 5'd0);
        runR("xor", OP_SPECIAL, FN_XOR, ALU_XOR, 5'd2, 5'd7, 5'd14, 5'd0);
        runR("nor", OP_SPECIAL, FN_NOR, ALU_NOR, 5'd1, 5'd2, 5'd15, 5'd0);
        runR("slt neg pos", OP_SPECIAL, FN_SLT, ALU_SLT, 5'd3, 5'd4, 5'd16, 5'd0);
        runR("slt pos neg", OP_SPECIAL, FN_SLT, ALU_SLT, 5'd4, 5'd3, 5'd17, 5'd0);
        runR("sltu big small", OP_SPECIAL, FN_SLTU, ALU_SLTU, 5'd3, 5'd4, 5'd18, 5'd0);
        runR("slt minus one", OP_SPECIAL, FN_SLT, ALU_SLT, 5'd5, 5'd6, 5'd19, 5'd0);
        runR("sltu minus one", OP_SPECIAL, FN_SLTU, ALU_SLTU, 5'd5, 5'd6, 5'd20, 5'd0);
        runR("slt random", OP_SPECIAL, FN_SLT, ALU_SLT, 5'd1, 5'd2, 5'd21, 5'd0);
        runR("sltu random", OP_SPECIAL, FN_SLTU, ALU_SLTU, 5'd1, 5'd2, 5'd22, 5'd0);
        runR("mul random", OP_SPECIAL2, FN_MUL, ALU_MUL, 5'd1, 5'd2, 5'd23, 5'd0);
        runR("mul negative", OP_SPECIAL2, FN_MUL, ALU_MUL, 5'd5, 5'd7, 5'd24, 5'd0);
        runR("addu to r0", OP_SPECIAL, FN_ADDU, ALU_ADD, 5'd1, 5'd2, 5'd0, 5'd0);
    endtask

    task automatic testShifts();
        logic [4:0] amounts [3];
        amounts = '{5'd0, 5'd1, 5'd31};
        foreach (amounts[k]) begin
            runR($sformatf("sll shamt %0d", amounts[k]), OP_SPECIAL, FN_SLL, ALU_SLL,
                 5'd0, 5'd7, 5'd25, amounts[k]);
            runR($sformatf("srl shamt %0d", amounts[k]), OP_SPECIAL, FN_SRL, ALU_SRL,
                 5'd0, 5'd3, 5'd26, amounts[k]);
            runR($sformatf("sra shamt %0d", amounts[k]), OP_SPECIAL, FN_SRA, ALU_SRA,
                 5'd0, 5'd3, 5'd27, amounts[k]);
        end
        loadReg(5'd28, 32'd0);                              // shift amounts in rs
        loadReg(5'd29, 32'd1);
        loadReg(5'd30, 32'd31);
        loadReg(5'd31, 32'd32);                             // wraps to 0
        for (int r = 28; r < 32; r++) begin
            runR($sformatf("sllv by r%0d", r), OP_SPECIAL, FN_SLLV, ALU_SLL,
                 5'(r), 5'd7, 5'd25, 5'd0);
            runR($sformatf("srlv by r%0d", r), OP_SPECIAL, FN_SRLV, ALU_SRL,
                 5'(r), 5'd3, 5'd26, 5'd0);
            runR($sformatf("srav by r%0d", r), OP_SPECIAL, FN_SRAV, ALU_SRA,
                 5'(r), 5'd3, 5'd27, 5'd0);
        end
    endtask

    task automatic testIType();
        runI("addiu negative", OP_ADDIU, ALU_ADD, 5'd1, 5'd8, 16'hfff0);
        runI("addi wraps", OP_ADDI, ALU_ADD, 5'd4, 5'd9, 16'h0001);
        runI("slti negative imm", OP_SLTI, ALU_SLT, 5'd6, 5'd10, 16'hffff);
        runI("slti most negative", OP_SLTI, ALU_SLT, 5'd3, 5'd11, 16'h8000);
        runI("sltiu sign extended", OP_SLTIU, ALU_SLTU, 5'd4, 5'd12, 16'hffff);
        runI("sltiu above", OP_SLTIU, ALU_SLTU, 5'd3, 5'd13, 16'h8000);
        runI("andi zero ext", OP_ANDI, ALU_AND, 5'd5, 5'd14, 16'h8001);
        runI("ori zero ext", OP_ORI, ALU_OR, 5'd3, 5'd15, 16'hf00f);
        runI("xori zero ext", OP_XORI, ALU_XOR, 5'd5, 5'd16, 16'h8000);
        runI("lui", OP_LUI, ALU_LUI, 5'd0, 5'd17, 16'hbeef);
        runI("addiu to r0", OP_ADDIU, ALU_ADD, 5'd5, 5'd0, 16'h1234);
    endtask

    task automatic testStatus();
        logic [31:0] rdata;
        logic [31:0] word;
        apbRead(ADDR_STATUS, rdata);
        checkStatus("count after legal ops", 1'b0, 16'(legalCount), rdata);
        word = {6'h23, 5'd1, 5'd9, 16'h0004};               // lw, not supported
        apbWrite(ADDR_INSTR, word, 1);                      // ends on the illegal pulse
        apbRead(ADDR_STATUS, rdata);
        checkStatus("illegal opcode", 1'b1, 16'(legalCount), rdata);
        apbRead(ADDR_INSTR, rdata);
        checkWord("instr readback", word, rdata);
        compareAllRegs("regs after illegal");
        apbWrite(ADDR_STATUS, 32'd0, 0);
        apbRead(ADDR_STATUS, rdata);
        checkStatus("flag cleared", 1'b0, 16'(legalCount), rdata);
        word = {OP_SPECIAL, 5'd1, 5'd2, 5'd9, 5'd0, 6'h08};  // jr
        apbWrite(ADDR_INSTR, word, 1);
        apbRead(ADDR_STATUS, rdata);
        checkStatus("illegal funct", 1'b1, 16'(legalCount), rdata);
        apbWrite(ADDR_STATUS, 32'd0, 0);
        runR("addu after illegal", OP_SPECIAL, FN_ADDU, ALU_ADD, 5'd1, 5'd6, 5'd18, 5'd0);
        apbRead(ADDR_STATUS, rdata);
        checkStatus("final count", 1'b0, 16'(legalCount), rdata);
        apbRead(ADDR_INSTR, rdata);
        checkWord("last instr readback", {OP_SPECIAL, 5'd1, 5'd6, 5'd18, 5'd0, FN_ADDU}, rdata);
    endtask

    initial begin
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 32'd0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;
        testRegFile();
        testRType();
        testShifts();
        testIType();
        testStatus();
        finishRun();
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/mipsAluPkg.sv
verilog/apbSlave.sv
verilog/instrDecoder.sv
verilog/arithLogicUnit.sv
verilog/regFile.sv
verilog/mipsAluTop.sv
testbench/tbMipsAlu.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tbMipsAlu \
    -f build.f -Mdir obj_dir -o tbMipsAlu
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tbMipsAlu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
